// ==== pdp8_core.f ====
source/isa_pkg.sv
source/control_pkg.sv
source/core_bus.sv
source/instruction_sequencer.sv
source/accumulator_unit.sv
source/address_unit.sv
source/panel_memory_port.sv
source/pdp8_core.sv
test/clock_gen.sv
test/pdp8_core_assertions.sv
test/pdp8_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module pdp8_core_tb \
  -f pdp8_core.f > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vpdp8_core_tb > sim.log 2>&1 || { cat sim.log; echo "Simulation stopped"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "Simulation failed"; exit 1; } \
  || echo "Simulation passed"

// ==== source/accumulator_unit.sv ====
//**************************************************************************
// AC has no reset and is cleared by the init cycle; link clears on reset
//**************************************************************************
module accumulator_unit
  import isa_pkg::*, control_pkg::*;
(
  input  logic  clock,
  input  logic  resetN,
  input  word_t switch_reg,
  core_bus.acc  bus
);

  logic [WORD_BITS:0] sum;

  assign sum = {1'b0, bus.ac} + {1'b0, bus.mb};

  always_ff @(posedge clock) begin
    case (bus.ac_op)
      AC_CLEAR: bus.ac <= '0;
      AC_SWREG: bus.ac <= switch_reg;
      AC_AND:   bus.ac <= bus.ac & bus.mb;
      AC_TAD:   bus.ac <= sum[WORD_BITS-1:0];
      default:  ;
    endcase
  end

  // Carry out of TAD complements the link
  always_ff @(posedge clock, negedge resetN)
    if (!resetN)
      bus.link <= 1'b0;
    else if (bus.ac_op == AC_TAD && sum[WORD_BITS])
      bus.link <= ~bus.link;

endmodule

// ==== source/address_unit.sv ====
//**************************************************************************
// Current page is taken from PC after the fetch increment
//**************************************************************************
module address_unit
  import isa_pkg::*, control_pkg::*;
(
  input  logic  clock,
  input  logic  resetN,
  input  word_t switch_reg,
  core_bus.addr bus
);

  logic [OFFSET_BITS-1:0] offset;

  assign offset = bus.ir[OFFSET_BITS-1:0];

  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN) begin
      bus.pc <= '0;
      bus.ir <= '0;
    end
    else begin
      case (bus.pc_op)
        PC_P1:   bus.pc <= bus.pc + 1'b1;
        PC_SR:   bus.pc <= switch_reg;
        PC_EA:   bus.pc <= bus.ea;
        default: ;
      endcase
      if (bus.ir_load) bus.ir <= bus.rd_data;
    end
  end

  always_ff @(posedge clock) begin
    case (bus.ea_op)
      EA_ZERO_PAGE: bus.ea <= {{(WORD_BITS-OFFSET_BITS){1'b0}}, offset};
      EA_CURR_PAGE: bus.ea <= {bus.pc[WORD_BITS-1:OFFSET_BITS], offset};
      EA_IND:       bus.ea <= bus.rd_data;  // Pointer word from memory
      default:      ;
    endcase
  end

endmodule

// ==== source/control_pkg.sv ====
//**************************************************************************
// Sequencer states and the operation codes it sends to the datapath
//**************************************************************************
package control_pkg;

  typedef enum logic [4:0] {
    REG_INIT,
    CPU_IDLE,
    EXAM_1, EXAM_2,
    LD_PC_1,
    LD_AC_1,
    DEP_1,
    FETCH_1, FETCH_2,
    DECODE,
    CAL_EA,
    EA_IND_1, EA_IND_2,
    AND_1, AND_2, AND_3,
    TAD_1, TAD_2, TAD_3,
    ISZ_1, ISZ_2, ISZ_3, ISZ_4, ISZ_5,
    DCA_1, DCA_2,
    JMP_1,
    HALT
  } seq_state_t;

  typedef enum logic [2:0] {AC_NC, AC_CLEAR, AC_SWREG, AC_AND, AC_TAD} ac_op_t;

  typedef enum logic [1:0] {PC_NC, PC_P1, PC_SR, PC_EA} pc_op_t;

  typedef enum logic [1:0] {EA_NC, EA_ZERO_PAGE, EA_CURR_PAGE, EA_IND} ea_op_t;

  typedef enum logic [2:0] {MB_NC, MB_ZERO, MB_RD, MB_INC, MB_WD} mb_op_t;

  // Memory address source
  typedef enum logic [1:0] {AD_PC, AD_EA, AD_SR} ad_sel_t;

  // Memory write data source
  typedef enum logic [1:0] {WD_SR, WD_AC, WD_MB} wd_sel_t;

  // Codes match the panel select switches
  typedef enum logic [1:0] {DISP_PC, DISP_AC, DISP_IR, DISP_MB} disp_sel_t;

endpackage

// ==== source/core_bus.sv ====
//**************************************************************************
// Control and data paths between sequencer, AC, address and memory units
//**************************************************************************
interface core_bus
  import isa_pkg::*, control_pkg::*;
();

  ac_op_t ac_op;
  pc_op_t pc_op;
  ea_op_t ea_op;
  mb_op_t mb_op;
  ad_sel_t ad_sel;
  wd_sel_t wd_sel;
  logic ir_load;
  logic read_enable;
  logic write_enable;
  logic cpu_idle;

  word_t ac;
  logic link;
  word_t pc;
  word_t ir;
  word_t ea;
  word_t rd_data;
  word_t mb;
  logic mb_zero;
  logic mem_finished;

  modport sequencer (output ac_op, pc_op, ea_op, mb_op, ir_load, ad_sel, wd_sel,
                     read_enable, write_enable, cpu_idle,
                     input ir, mb_zero, mem_finished);
  modport acc (output ac, link, input ac_op, mb);
  modport addr (output pc, ir, ea, input pc_op, ea_op, ir_load, rd_data);
  modport mem (output rd_data, mb, mb_zero, mem_finished,
               input mb_op, ad_sel, wd_sel, read_enable, write_enable, cpu_idle,
               pc, ea, ir, ac);

endinterface

// ==== source/instruction_sequencer.sv ====
//**************************************************************************
// Panel commands are sampled only in idle; run is ignored after HALT until
// it drops. JMS, IOT and OPR words (except 7402) are no-ops
//**************************************************************************
module instruction_sequencer
  import isa_pkg::*, control_pkg::*;
(
  input  logic clock,
  input  logic resetN,
  input  logic run,
  input  logic step,
  input  logic examine,
  input  logic load_pc,
  input  logic load_ac,
  input  logic deposit,
  output logic halt,
  core_bus.sequencer bus
);

  seq_state_t state, next_state, inst_state;
  opcode_t opcode;
  logic run_hold;

  assign opcode = opcode_t'(bus.ir[OPCODE_MSB:OPCODE_LSB]);

  always_ff @(posedge clock, negedge resetN)
    if (!resetN) state <= REG_INIT;
    else         state <= next_state;

  // Blocks run from restarting the program right after a HALT
  always_ff @(posedge clock, negedge resetN)
    if (!resetN)            run_hold <= 1'b0;
    else if (state == HALT) run_hold <= 1'b1;
    else if (!run)          run_hold <= 1'b0;

  // First state of the execute chain
  always_comb begin
    case (opcode)
      OP_AND:  inst_state = AND_1;
      OP_TAD:  inst_state = TAD_1;
      OP_ISZ:  inst_state = ISZ_1;
      OP_DCA:  inst_state = DCA_1;
      default: inst_state = JMP_1;  // Only JMP reaches here
    endcase
  end

  always_comb begin
    next_state = state;
    case (state)
      REG_INIT: next_state = CPU_IDLE;
      CPU_IDLE: begin
        if (run && !run_hold) next_state = FETCH_1;
        else if (step)        next_state = FETCH_1;
        else if (examine)     next_state = EXAM_1;
        else if (load_pc)     next_state = LD_PC_1;
        else if (load_ac)     next_state = LD_AC_1;
        else if (deposit)     next_state = DEP_1;
      end
      EXAM_1:   if (bus.mem_finished) next_state = EXAM_2;
      DEP_1:    if (bus.mem_finished) next_state = CPU_IDLE;
      FETCH_1:  if (bus.mem_finished) next_state = FETCH_2;
      FETCH_2:  next_state = DECODE;
      DECODE: begin
        if (bus.ir == HALT_CODE) next_state = HALT;
        else begin
          case (opcode)
            OP_JMS, OP_IOT, OP_OPR: next_state = CPU_IDLE;
            default:                next_state = CAL_EA;
          endcase
        end
      end
      CAL_EA:   next_state = bus.ir[IND_BIT] ? EA_IND_1 : inst_state;
      EA_IND_1: if (bus.mem_finished) next_state = EA_IND_2;
      EA_IND_2: next_state = inst_state;
      AND_1:    if (bus.mem_finished) next_state = AND_2;
      AND_2:    next_state = AND_3;
      TAD_1:    if (bus.mem_finished) next_state = TAD_2;
      TAD_2:    next_state = TAD_3;
      ISZ_1:    if (bus.mem_finished) next_state = ISZ_2;
      ISZ_2:    next_state = ISZ_3;
      ISZ_3:    next_state = ISZ_4;
      ISZ_4:    if (bus.mem_finished) next_state = ISZ_5;
      DCA_1:    if (bus.mem_finished) next_state = DCA_2;
      default:  next_state = CPU_IDLE;  // Last state of every chain
    endcase
  end

  always_comb begin
    bus.ac_op = AC_NC;
    bus.pc_op = PC_NC;
    bus.ea_op = EA_NC;
    bus.mb_op = MB_NC;
    bus.ir_load = 1'b0;
    bus.ad_sel = AD_PC;
    bus.wd_sel = WD_AC;
    bus.read_enable = 1'b0;
    bus.write_enable = 1'b0;
    bus.cpu_idle = 1'b0;
    halt = 1'b0;
    case (state)
      REG_INIT: begin
        bus.ac_op = AC_CLEAR;
        bus.mb_op = MB_ZERO;
      end
      CPU_IDLE: bus.cpu_idle = 1'b1;
      EXAM_1: begin
        bus.ad_sel = AD_SR;
        bus.read_enable = 1'b1;
      end
      LD_PC_1:  bus.pc_op = PC_SR;
      LD_AC_1:  bus.ac_op = AC_SWREG;
      DEP_1: begin
        bus.wd_sel = WD_SR;
        bus.write_enable = 1'b1;
        if (bus.mem_finished) bus.pc_op = PC_P1;  // Address still PC at this edge
      end
      FETCH_1:  bus.read_enable = 1'b1;
      FETCH_2: begin
        bus.ir_load = 1'b1;
        bus.pc_op = PC_P1;
      end
      CAL_EA:   bus.ea_op = bus.ir[PAGE_BIT] ? EA_CURR_PAGE : EA_ZERO_PAGE;
      EA_IND_1, AND_1, TAD_1, ISZ_1: begin
        bus.ad_sel = AD_EA;
        bus.read_enable = 1'b1;
      end
      EA_IND_2: bus.ea_op = EA_IND;
      EXAM_2, AND_2, TAD_2, ISZ_2: bus.mb_op = MB_RD;
      AND_3:    bus.ac_op = AC_AND;
      TAD_3:    bus.ac_op = AC_TAD;
      ISZ_3:    bus.mb_op = MB_INC;
      ISZ_4: begin
        bus.ad_sel = AD_EA;
        bus.wd_sel = WD_MB;
        bus.write_enable = 1'b1;
      end
      ISZ_5:    if (bus.mb_zero) bus.pc_op = PC_P1;
      DCA_1: begin
        bus.ad_sel = AD_EA;
        bus.write_enable = 1'b1;
      end
      DCA_2: begin
        bus.mb_op = MB_WD;  // MB keeps the stored AC
        bus.ac_op = AC_CLEAR;
      end
      JMP_1:    bus.pc_op = PC_EA;
      HALT: begin
        halt = 1'b1;
        bus.cpu_idle = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== source/isa_pkg.sv ====
//**************************************************************************
// Word format and instruction fields of the 12-bit machine
//**************************************************************************
package isa_pkg;

  localparam int WORD_BITS = 12;

  typedef logic [WORD_BITS-1:0] word_t;

  // Operation field, bits 11 to 9
  typedef enum logic [2:0] {
    OP_AND,
    OP_TAD,
    OP_ISZ,
    OP_DCA,
    OP_JMS,
    OP_JMP,
    OP_IOT,
    OP_OPR
  } opcode_t;

  localparam word_t HALT_CODE = 12'o7402;

  localparam int OPCODE_MSB = 11;
  localparam int OPCODE_LSB = 9;
  localparam int IND_BIT = 8;      // Indirect addressing
  localparam int PAGE_BIT = 7;     // 0 zero page, 1 current page
  localparam int OFFSET_BITS = 7;  // Page offset in bits 6 to 0

endpackage

// ==== source/panel_memory_port.sv ====
//**************************************************************************
// MEM_WAIT_CYCLES must be 1 to 8; rd_data is valid the cycle after finish
//**************************************************************************
module panel_memory_port
  import isa_pkg::*, control_pkg::*;
#(
  parameter int MEM_WAIT_CYCLES = 2
)(
  input  logic       clock,
  input  logic       resetN,
  input  word_t      switch_reg,
  input  logic [1:0] disp_sel,
  output word_t      display_out,
  core_bus.mem       bus
);

  localparam int MEM_WORDS = 1 << WORD_BITS;

  word_t mem [MEM_WORDS];
  word_t mem_addr;
  word_t wr_data;
  logic [3:0] wait_cnt;
  logic access;

  always_comb begin
    case (bus.ad_sel)
      AD_PC:   mem_addr = bus.pc;
      AD_EA:   mem_addr = bus.ea;
      default: mem_addr = switch_reg;
    endcase
    case (bus.wd_sel)
      WD_SR:   wr_data = switch_reg;
      WD_AC:   wr_data = bus.ac;
      default: wr_data = bus.mb;
    endcase
  end

  assign access = bus.read_enable | bus.write_enable;
  assign bus.mem_finished = access && (wait_cnt == 4'(MEM_WAIT_CYCLES - 1));
  assign bus.mb_zero = (bus.mb == '0);

  // Counts cycles with an enable held
  always_ff @(posedge clock, negedge resetN)
    if (!resetN)                          wait_cnt <= '0;
    else if (!access || bus.mem_finished) wait_cnt <= '0;
    else                                  wait_cnt <= wait_cnt + 1'b1;

  always_ff @(posedge clock) begin
    if (bus.write_enable && bus.mem_finished) mem[mem_addr] <= wr_data;
    if (bus.read_enable && bus.mem_finished)  bus.rd_data <= mem[mem_addr];
    case (bus.mb_op)
      MB_ZERO: bus.mb <= '0;
      MB_RD:   bus.mb <= bus.rd_data;
      MB_INC:  bus.mb <= bus.mb + 1'b1;
      MB_WD:   bus.mb <= wr_data;
      default: ;
    endcase
  end

  // Panel lamps follow the selected register only while idle
  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN)
      display_out <= '0;
    else if (bus.cpu_idle) begin
      case (disp_sel_t'(disp_sel))
        DISP_PC: display_out <= bus.pc;
        DISP_AC: display_out <= bus.ac;
        DISP_IR: display_out <= bus.ir;
        default: display_out <= bus.mb;
      endcase
    end
  end

endmodule

// ==== source/pdp8_core.sv ====
//**************************************************************************
// 12-bit core with front panel and 4K words of internal memory
//**************************************************************************
module pdp8_core
  import isa_pkg::*;
#(
  parameter int MEM_WAIT_CYCLES = 2
)(
  input  logic       clock,
  input  logic       resetN,
  input  word_t      switch_reg,
  input  logic       run,
  input  logic       step,
  input  logic       examine,
  input  logic       load_pc,
  input  logic       load_ac,
  input  logic       deposit,
  input  logic [1:0] disp_sel,
  output word_t      display_out,
  output logic       link,
  output logic       halt,
  output logic       cpu_idle
);

  core_bus bus ();

  instruction_sequencer sequencer0 (
    .clock, .resetN,
    .run, .step, .examine, .load_pc, .load_ac, .deposit,
    .halt,
    .bus (bus.sequencer)
  );

  accumulator_unit acc0 (.clock, .resetN, .switch_reg, .bus (bus.acc));

  address_unit addr0 (.clock, .resetN, .switch_reg, .bus (bus.addr));

  panel_memory_port #(
    .MEM_WAIT_CYCLES (MEM_WAIT_CYCLES)
  ) mem0 (
    .clock, .resetN,
    .switch_reg,
    .disp_sel,
    .display_out,
    .bus (bus.mem)
  );

  assign link = bus.link;
  assign cpu_idle = bus.cpu_idle;

endmodule

// ==== test/clock_gen.sv ====
//**************************************************************************
// Reset is released on a falling edge after RESET_CYCLES rising edges
//**************************************************************************
module clock_gen #(
  parameter int PERIOD = 8,
  parameter int RESET_CYCLES = 2
)(
  output logic clock,
  output logic resetN
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  initial begin
    resetN = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;
  end

endmodule

// ==== test/pdp8_core_assertions.sv ====
//**************************************************************************
// Bound into the sequencer; checks the memory enables and the halt strobe
//**************************************************************************
module pdp8_core_assertions (
  input logic clock,
  input logic resetN,
  input logic halt,
  input logic cpu_idle,
  input logic read_enable,
  input logic write_enable,
  input logic mem_finished
);

  one_enable: assert property (@(posedge clock) disable iff (!resetN)
    !(read_enable && write_enable))
    else $error("Read and write enables are high together");

  idle_no_access: assert property (@(posedge clock) disable iff (!resetN)
    cpu_idle |-> !(read_enable || write_enable))
    else $error("Memory enable is high while the core is idle");

  // HALT is a single idle cycle and the core stays idle after it
  halt_one_cycle: assert property (@(posedge clock) disable iff (!resetN)
    halt |-> cpu_idle ##1 (cpu_idle && !halt))
    else $error("Halt is not one idle cycle followed by idle");

  finish_drops_enable: assert property (@(posedge clock) disable iff (!resetN)
    mem_finished |=> !(read_enable || write_enable))
    else $error("Memory enable still high after the access finished");

endmodule

bind instruction_sequencer pdp8_core_assertions assertions0 (
  .clock, .resetN, .halt,
  .cpu_idle     (bus.cpu_idle),
  .read_enable  (bus.read_enable),
  .write_enable (bus.write_enable),
  .mem_finished (bus.mem_finished)
);

// ==== test/pdp8_core_tb.sv ====
//**************************************************************************
// Trace operands and expected values are octal; each record waits for idle
//**************************************************************************
module pdp8_core_tb
  import isa_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 300;

  logic clock, resetN;
  word_t switch_reg, display_out;
  logic run, step, examine, load_pc, load_ac, deposit;
  logic [1:0] disp_sel;
  logic link, halt, cpu_idle;

  int fd, tests, errors, operand, disp, expect_val, expect_link;
  string line, cmd, name;
  bit timed_out;

  clock_gen clock_gen0 (.clock, .resetN);

  pdp8_core dut0 (
    .clock, .resetN, .switch_reg, .run, .step, .examine, .load_pc, .load_ac,
    .deposit, .disp_sel, .display_out, .link, .halt, .cpu_idle
  );

  task automatic wait_for_idle();
    int count;
    count = 0;
    while (cpu_idle !== 1'b1 && count < TIMEOUT_CYCLES) begin
      @(negedge clock);
      count++;
    end
    if (cpu_idle !== 1'b1) begin
      $display("Timeout: core never returned to idle in %s", name);
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_for_halt();
    int count;
    count = 0;
    while (halt !== 1'b1 && count < TIMEOUT_CYCLES) begin
      @(negedge clock);
      count++;
    end
    if (halt !== 1'b1) begin
      $display("Timeout: program never reached HALT in %s", name);
      timed_out = 1'b1;
    end
  endtask

  task automatic apply_record();
    int errors_before;
    errors_before = errors;
    switch_reg = word_t'(operand);
    if (cmd == "run") run = 1'b1;
    else if (cmd == "step") step = 1'b1;
    else if (cmd == "exam") examine = 1'b1;
    else if (cmd == "ldpc") load_pc = 1'b1;
    else if (cmd == "ldac") load_ac = 1'b1;
    else if (cmd == "dep") deposit = 1'b1;
    else if (cmd != "reset" && cmd != "show") begin
      $display("Unknown command %s in the trace", cmd);
      errors++;
    end
    if (cmd == "run") wait_for_halt();  // Run stays high until HALT
    else if (cmd != "reset" && cmd != "show") @(negedge clock);
    {run, step, examine, load_pc, load_ac, deposit} = '0;
    if (!timed_out) wait_for_idle();
    if (!timed_out) begin
      disp_sel = 2'(disp);
      @(negedge clock);  // Display loads on the idle edge in between
      if (display_out !== word_t'(expect_val)) begin
        $display("ERR %s: expected %04o, actual %04o", name, word_t'(expect_val), display_out);
        errors++;
      end
      if (link !== expect_link[0]) begin
        $display("ERR %s: expected link %0d, actual %0d", name, expect_link[0], link);
        errors++;
      end
      if (cmd == "reset" && halt !== 1'b0) begin
        $display("Halt is high after reset in %s", name);
        errors++;
      end
    end
    tests++;
    $display("test %s %s", name, (errors == errors_before && !timed_out) ? "passed" : "failed");
  endtask

  initial begin
    int count;
    {run, step, examine, load_pc, load_ac, deposit} = '0;
    switch_reg = '0;
    disp_sel = '0;
    errors = 0;
    tests = 0;
    timed_out = 1'b0;
    count = 0;
    while (resetN !== 1'b1 && count < TIMEOUT_CYCLES) begin
      @(negedge clock);
      count++;
    end
    if (resetN !== 1'b1) begin
      $display("Timeout: reset was never released");
      timed_out = 1'b1;
    end
    fd = $fopen("test/pdp8_core_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the trace file");
      errors++;
    end
    while (fd != 0 && !timed_out && !$feof(fd)) begin
      if ($fgets(line, fd) > 0 && line.getc(0) != "#") begin
        if ($sscanf(line, "%s %o %d %o %d %s", cmd, operand, disp, expect_val,
                    expect_link, name) == 6)
          apply_record();
      end
    end
    if (fd != 0) $fclose(fd);
    if (tests == 0) begin
      $display("No records were read from the trace");
      errors++;
    end
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0 && !timed_out) begin
      $display("PASS: all tests");
    end
    else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== test/pdp8_core_trace.txt ====
# command operand disp expected link name; operand and expected are octal
# disp selects 0 PC, 1 AC, 2 IR, 3 MB; link is the expected link bit
reset 0000 1 0000 0 reset_state
ldpc  0200 0 0200 0 panel_load_pc
dep   0020 0 0201 0 panel_dep_0200
dep   1021 0 0202 0 panel_dep_0201
dep   1022 0 0203 0 panel_dep_0202
exam  0200 3 0020 0 panel_exam_0200
exam  0201 3 1021 0 panel_exam_0201
exam  0202 3 1022 0 panel_exam_0202
show  0000 0 0203 0 panel_pc_after
dep   3027 0 0204 0 prog_dca
dep   2023 0 0205 0 prog_isz_skip
dep   7402 0 0206 0 prog_skipped
dep   2024 0 0207 0 prog_isz_noskip
dep   5211 0 0210 0 prog_jmp
dep   7402 0 0211 0 prog_jumped_over
dep   1425 0 0212 0 prog_tad_ind
dep   1026 0 0213 0 prog_tad
dep   7402 0 0214 0 prog_halt
ldpc  0020 0 0020 0 data_base
dep   0770 0 0021 0 data_and_mask
dep   6000 0 0022 0 data_tad_a
dep   3123 0 0023 0 data_tad_b
dep   7777 0 0024 0 data_isz_wrap
dep   0005 0 0025 0 data_isz_count
dep   0201 0 0026 0 data_pointer
dep   0001 0 0027 0 data_increment
ldac  1234 1 1234 0 load_ac
ldpc  0200 0 0200 0 prog_start
step  0000 1 0230 0 and_mask
step  0000 1 6230 0 tad_no_carry
step  0000 1 1353 1 tad_carry
step  0000 1 0000 1 dca_clears_ac
exam  0027 3 1353 1 dca_stored
step  0000 0 0206 1 isz_skip_pc
step  0000 0 0207 1 isz_noskip_pc
exam  0023 3 0000 1 isz_wrapped
exam  0024 3 0006 1 isz_counted
step  0000 0 0211 1 jmp_curr_page
step  0000 1 1021 1 tad_indirect
run   0000 0 0214 1 halt_pc
show  0000 1 1022 1 halt_ac
